// File: mmu_checker.sv
// control rules of the matrix-multiply top, attached to every mmu_top by the bind below
`timescale 1ns/1ps

module mmu_checker (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   busy,
    input logic                   done,
    input tpu_bus_pkg::host_wr_t  host_wr,                          // host write strobe
    input tpu_bus_pkg::data_row_t imem [tpu_cfg_pkg::MEM_DEPTH],    // input memory rows
    input tpu_bus_pkg::data_row_t wmem [tpu_cfg_pkg::MEM_DEPTH]     // weight memory rows
);

    int fail_cnt = 0;                             // failed assertions, summed by the testbench

    // no stray done pulse when reset releases
    a_done_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !done)
        else begin
            $error("done high in the first cycle after reset");
            fail_cnt++;
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
        else begin
            $error("done held longer than one cycle");
            fail_cnt++;
        end

    // busy drops on the same edge that raises done
    a_done_busy: assert property (@(posedge clk) disable iff (!arst_n) done |-> $past(busy))
        else begin
            $error("done raised outside a run");
            fail_cnt++;
        end

    // a write issued during a run leaves both addressed rows as they were
    a_no_wr_busy: assert property (@(posedge clk) disable iff (!arst_n)
        busy && host_wr.valid
        |=> imem[$past(host_wr.addr)] === $past(imem[host_wr.addr])
            && wmem[$past(host_wr.addr)] === $past(wmem[host_wr.addr]))
        else begin
            $error("host write reached a memory during a run");
            fail_cnt++;
        end

endmodule

bind mmu_top mmu_checker u_chk (
    .clk(clk), .arst_n(arst_n), .busy(busy), .done(done), .host_wr(host_wr),
    .imem(u_imem.mem_q), .wmem(u_wmem.mem_q));

// File: mmu_tb.sv
// testbench for mmu_top: loads rows, runs the array, reads results back against a reference
`timescale 1ns/1ps

module mmu_tb;

    localparam int CLK_PERIOD  = 20;
    localparam int NUM_RUNS    = 6;               // five tests, the last one runs twice
    localparam int RUN_CYCLES  = 3 * tpu_cfg_pkg::N + tpu_cfg_pkg::MEM_DEPTH
                                 + tpu_cfg_pkg::ARRAY_LAT + 20;
    localparam int LOAD_CYCLES = 2 * tpu_cfg_pkg::MEM_DEPTH + 2 * tpu_cfg_pkg::N + 16;
    localparam int WDOG_CYCLES = NUM_RUNS * (RUN_CYCLES + LOAD_CYCLES) + 10;

    logic                            clk;
    logic                            arst_n;
    tpu_bus_pkg::host_wr_t           host_wr;
    logic                            start;
    logic [tpu_cfg_pkg::CNT_W-1:0]  num_rows;
    logic                            busy;
    logic                            done;
    logic                            out_rd_en;
    logic [tpu_cfg_pkg::ADDR_W-1:0] out_rd_addr;
    tpu_bus_pkg::acc_row_t           out_rd_data;

    tpu_bus_pkg::data_row_t in_sh [tpu_cfg_pkg::MEM_DEPTH];  // what the input mem should hold
    tpu_bus_pkg::data_row_t w_sh  [tpu_cfg_pkg::N];          // what the weight mem should hold
    tpu_bus_pkg::acc_row_t  saved [tpu_cfg_pkg::MEM_DEPTH];  // earlier run's expected rows
    tpu_bus_pkg::acc_row_t  exp_q [$];            // expected rows in read order
    string                  name_q [$];
    logic [31:0]            rng;                  // xorshift state
    logic                   rd_pend;              // read data arrives this cycle
    int err_count, check_count, test_count, test_fails, test_err0;

    mmu_top DUT (
        .clk(clk), .arst_n(arst_n), .host_wr(host_wr), .start(start), .num_rows(num_rows),
        .busy(busy), .done(done), .out_rd_en(out_rd_en), .out_rd_addr(out_rd_addr),
        .out_rd_data(out_rd_data));

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ====================
    // stimulus helpers
    // ====================
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic tpu_bus_pkg::data_row_t rand_row();
        rng = xorshift(rng);
        return tpu_bus_pkg::data_row_t'(rng);     // four random bytes
    endfunction

    // out[r][c] = relu(sum over k of in[r][k] * w[k][c])
    function automatic tpu_bus_pkg::acc_row_t ref_row(input int r);
        tpu_bus_pkg::acc_row_t res;
        int sum;
        int a;
        int b;
        for (int c = 0; c < tpu_cfg_pkg::N; c++) begin
            sum = 0;
            for (int k = 0; k < tpu_cfg_pkg::N; k++) begin
                a = $signed(in_sh[r][k]);
                b = $signed(w_sh[k][c]);
                sum += a * b;
            end
            res[c] = (sum < 0) ? '0 : tpu_bus_pkg::acc_elem_t'(sum);
        end
        return res;
    endfunction

    task automatic write_row(input logic sel, input int addr,
                             input tpu_bus_pkg::data_row_t data, input bit keep);
        tpu_bus_pkg::host_wr_t w;
        w.valid = 1'b1;
        w.sel   = sel;
        w.addr  = tpu_cfg_pkg::ADDR_W'(addr);
        w.data  = data;
        @(posedge clk);
        host_wr <= w;
        if (keep && sel) begin
            w_sh[addr] = data;
        end else if (keep) begin
            in_sh[addr] = data;                   // dropped writes leave the shadow alone
        end
    endtask

    task automatic end_writes();
        @(posedge clk);
        host_wr <= '0;
    endtask

    task automatic start_run(input int n);
        @(posedge clk);
        start    <= 1'b1;
        num_rows <= tpu_cfg_pkg::CNT_W'(n);
        @(posedge clk);
        start    <= 1'b0;
    endtask

    task automatic wait_done(input string name);
        int cyc;
        cyc = 0;
        @(negedge clk);
        while (!done && cyc < RUN_CYCLES) begin
            @(negedge clk);
            cyc++;
        end
        if (!done) begin
            $display("%s: done never seen within %0d cycles", name, RUN_CYCLES);
            err_count++;
        end else if (busy) begin
            $display("%s: busy stuck high in the done cycle", name);
            err_count++;
        end
    endtask

    // ====================
    // result read and compare
    // ====================
    task automatic read_row(input string name, input int r, input tpu_bus_pkg::acc_row_t exp);
        @(posedge clk);
        out_rd_en   <= 1'b1;
        out_rd_addr <= tpu_cfg_pkg::ADDR_W'(r);
        exp_q.push_back(exp);
        name_q.push_back($sformatf("%s row %0d", name, r));
    endtask

    task automatic read_end();
        @(posedge clk);
        out_rd_en <= 1'b0;
        repeat (2) @(negedge clk);                // let the compare process drain
    endtask

    task automatic check_rows(input string name, input int n);
        for (int r = 0; r < n; r++) begin
            read_row(name, r, ref_row(r));
        end
        read_end();
    endtask

    task automatic check_row(input string name, input tpu_bus_pkg::acc_row_t exp,
                             input tpu_bus_pkg::acc_row_t act);
        check_count++;
        if (act !== exp) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (err_count == test_err0) begin
            $display("test %s: ok", name);
        end else begin
            test_fails++;
            $display("test %s: %0d errors", name, err_count - test_err0);
        end
        test_err0 = err_count;
    endtask

    always @(posedge clk) rd_pend <= out_rd_en;   // memory read latency of one

    always @(negedge clk) begin
        if (rd_pend && exp_q.size() > 0) begin
            check_row(name_q.pop_front(), exp_q.pop_front(), out_rd_data);
        end
    end

    // ====================
    // tests
    // ====================
    initial begin
        tpu_bus_pkg::data_row_t row;
        clk         = 1'b0;
        arst_n      = 1'b0;
        host_wr     = '0;
        start       = 1'b0;
        num_rows    = '0;
        out_rd_en   = 1'b0;
        out_rd_addr = '0;
        rd_pend     = 1'b0;
        rng         = 32'h385e_887c;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        test_fails  = 0;
        test_err0   = 0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        // identity weights pass inputs through the clamp
        for (int k = 0; k < tpu_cfg_pkg::N; k++) begin
            row    = '0;
            row[k] = 8'sd1;
            write_row(1'b1, k, row, 1'b1);
        end
        for (int r = 0; r < tpu_cfg_pkg::MEM_DEPTH; r++) write_row(1'b0, r, rand_row(), 1'b1);
        end_writes();
        start_run(16);
        wait_done("identity");
        check_rows("identity", 16);
        end_test("identity");

        // random data, column 0 and row 0 at -128 for the largest sum
        for (int k = 0; k < tpu_cfg_pkg::N; k++) begin
            row    = rand_row();
            row[0] = 8'h80;
            write_row(1'b1, k, row, 1'b1);
        end
        write_row(1'b0, 0, {4{8'h80}}, 1'b1);
        for (int r = 1; r < tpu_cfg_pkg::MEM_DEPTH; r++) write_row(1'b0, r, rand_row(), 1'b1);
        end_writes();
        start_run(16);
        wait_done("random");
        check_rows("random", 16);
        end_test("random");

        // negative weights times non-negative inputs
        for (int k = 0; k < tpu_cfg_pkg::N; k++) begin
            write_row(1'b1, k, rand_row() | 32'h8080_8080, 1'b1);
        end
        for (int r = 0; r < tpu_cfg_pkg::MEM_DEPTH; r++) begin
            write_row(1'b0, r, rand_row() & 32'h7f7f_7f7f, 1'b1);
        end
        end_writes();
        start_run(16);
        wait_done("relu_clamp");
        check_rows("relu_clamp", 16);
        end_test("relu_clamp");

        // one negative row on the negative weights, every column positive over the zeros
        write_row(1'b0, 0, rand_row() | 32'h8080_8080, 1'b1);
        end_writes();
        start_run(1);
        wait_done("single_row");
        check_rows("single_row", 1);
        if (busy) begin
            $display("single_row: busy still high after the run");
            err_count++;
        end
        end_test("single_row");

        // first run fills all 16 rows
        for (int k = 0; k < tpu_cfg_pkg::N; k++) write_row(1'b1, k, rand_row(), 1'b1);
        for (int r = 0; r < tpu_cfg_pkg::MEM_DEPTH; r++) write_row(1'b0, r, rand_row(), 1'b1);
        end_writes();
        start_run(16);
        wait_done("back_to_back");
        check_rows("back_to_back", 16);
        for (int r = 0; r < tpu_cfg_pkg::MEM_DEPTH; r++) saved[r] = ref_row(r);

        // second run on new weights, writes and start during it must be dropped
        for (int k = 0; k < tpu_cfg_pkg::N; k++) write_row(1'b1, k, rand_row(), 1'b1);
        end_writes();
        start_run(10);
        for (int k = 0; k < tpu_cfg_pkg::N; k++) begin
            write_row(1'b1, k, rand_row(), 1'b0);
            write_row(1'b0, k, rand_row(), 1'b0);
        end
        end_writes();
        start_run(3);
        wait_done("back_to_back");
        for (int r = 0; r < tpu_cfg_pkg::MEM_DEPTH; r++) begin
            read_row("back_to_back", r, (r < 10) ? ref_row(r) : saved[r]);
        end
        read_end();
        if (busy) begin
            $display("back_to_back: busy rose again, a start during the run was taken");
            err_count++;
        end
        end_test("back_to_back");

        if (DUT.u_chk.fail_cnt != 0) begin
            $display("control checker saw %0d failed assertions", DUT.u_chk.fail_cnt);
            err_count += DUT.u_chk.fail_cnt;
        end
        $display("%0d tests, %0d failed, %0d row checks, %0d errors",
                 test_count, test_fails, check_count, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog sized from run and load length of every test
    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run did not finish", WDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: mmu_top.sv
// matrix-multiply unit top: memories, weight staging, array, sequencer and result writer
`timescale 1ns/1ps

module mmu_top (
    input  logic                            clk,
    input  logic                            arst_n,
    input  tpu_bus_pkg::host_wr_t           host_wr,       // input or weight row write
    input  logic                            start,
    input  logic [tpu_cfg_pkg::CNT_W-1:0]  num_rows,
    output logic                            busy,
    output logic                            done,
    input  logic                            out_rd_en,
    input  logic [tpu_cfg_pkg::ADDR_W-1:0] out_rd_addr,
    output tpu_bus_pkg::acc_row_t           out_rd_data
);

    logic                            wmem_rd_en,  imem_rd_en,  omem_wr_en;
    logic [tpu_cfg_pkg::ADDR_W-1:0] wmem_rd_addr, imem_rd_addr, omem_wr_addr;
    tpu_bus_pkg::data_row_t          wmem_rd_data, imem_rd_data, w_col;
    tpu_bus_pkg::acc_row_t           omem_wr_data;
    tpu_bus_pkg::arr_out_t           arr_out;
    logic fifo_push, w_shift, arr_row_valid, arr_row_last, wr_done;

    // host writes are dropped at the write enables while a run is busy
    row_mem #(.payload_t(tpu_bus_pkg::data_row_t)) u_imem (
        .clk(clk), .wr_en(host_wr.valid && !host_wr.sel && !busy),
        .wr_addr(host_wr.addr), .wr_data(host_wr.data),
        .rd_en(imem_rd_en), .rd_addr(imem_rd_addr), .rd_data(imem_rd_data));

    row_mem #(.payload_t(tpu_bus_pkg::data_row_t)) u_wmem (
        .clk(clk), .wr_en(host_wr.valid && host_wr.sel && !busy),
        .wr_addr(host_wr.addr), .wr_data(host_wr.data),
        .rd_en(wmem_rd_en), .rd_addr(wmem_rd_addr), .rd_data(wmem_rd_data));

    row_mem #(.payload_t(tpu_bus_pkg::acc_row_t)) u_omem (
        .clk(clk), .wr_en(omem_wr_en), .wr_addr(omem_wr_addr), .wr_data(omem_wr_data),
        .rd_en(out_rd_en), .rd_addr(out_rd_addr), .rd_data(out_rd_data));

    weight_fifo u_wfifo (
        .clk(clk), .arst_n(arst_n), .push(fifo_push), .shift(w_shift),
        .row_in(wmem_rd_data), .col_out(w_col));

    // row tags from the sequencer ride with the input memory read data
    sys_arr u_arr (
        .clk(clk), .arst_n(arst_n), .w_shift(w_shift), .w_in(w_col),
        .row_in(tpu_bus_pkg::arr_in_t'{arr_row_valid, arr_row_last, imem_rd_data}),
        .row_out(arr_out));

    seq_control u_seq (
        .clk(clk), .arst_n(arst_n), .start(start), .num_rows(num_rows),
        .wr_done(wr_done), .busy(busy), .done(done),
        .wmem_rd_en(wmem_rd_en), .wmem_rd_addr(wmem_rd_addr),
        .fifo_push(fifo_push), .w_shift(w_shift),
        .imem_rd_en(imem_rd_en), .imem_rd_addr(imem_rd_addr),
        .arr_row_valid(arr_row_valid), .arr_row_last(arr_row_last));

    out_writer u_owr (
        .clk(clk), .arst_n(arst_n), .row_in(arr_out),
        .omem_wr_en(omem_wr_en), .omem_wr_addr(omem_wr_addr),
        .omem_wr_data(omem_wr_data), .wr_done(wr_done));

endmodule

// File: out_writer.sv
// result deskew, ReLU clamp and output memory write with a per-run row address
`timescale 1ns/1ps

module out_writer (
    input  logic                            clk,
    input  logic                            arst_n,
    input  tpu_bus_pkg::arr_out_t           row_in,        // column c lags c cycles
    output logic                            omem_wr_en,
    output logic [tpu_cfg_pkg::ADDR_W-1:0] omem_wr_addr,
    output tpu_bus_pkg::acc_row_t           omem_wr_data,
    output logic                            wr_done        // write of the last row
);

    tpu_bus_pkg::acc_row_t       dsk_q [tpu_cfg_pkg::N-1];  // stage j delays by j+1
    logic [tpu_cfg_pkg::N-2:0]   vld_q;
    logic [tpu_cfg_pkg::N-2:0]   lst_q;
    logic                        last_q;          // written row closes the run
    tpu_bus_pkg::acc_row_t       aligned;         // all columns of one row

    // ====================
    // deskew
    // ====================
    always_ff @(posedge clk) begin
        dsk_q[0] <= row_in.data;
        for (int j = 1; j < tpu_cfg_pkg::N-1; j++) begin
            dsk_q[j] <= dsk_q[j-1];
        end
    end

    // column c waits N-1-c cycles, the rightmost column passes straight
    always_comb begin
        aligned = row_in.data;
        for (int c = 0; c < tpu_cfg_pkg::N-1; c++) begin
            aligned[c] = dsk_q[tpu_cfg_pkg::N-2-c][c];
        end
    end

    // ReLU register, feeds the memory write directly
    always_ff @(posedge clk) begin
        for (int c = 0; c < tpu_cfg_pkg::N; c++) begin
            omem_wr_data[c] <= (aligned[c] < 0) ? '0 : aligned[c];  // clamp negatives
        end
    end

    // ====================
    // write control
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q        <= '0;
            lst_q        <= '0;
            omem_wr_en   <= 1'b0;
            last_q       <= 1'b0;
            omem_wr_addr <= '0;
        end else begin
            vld_q      <= {vld_q[tpu_cfg_pkg::N-3:0], row_in.valid};
            lst_q      <= {lst_q[tpu_cfg_pkg::N-3:0], row_in.valid && row_in.last};
            omem_wr_en <= vld_q[tpu_cfg_pkg::N-2];
            last_q     <= lst_q[tpu_cfg_pkg::N-2];
            if (omem_wr_en) begin
                omem_wr_addr <= last_q ? '0 : omem_wr_addr + 1'b1;  // next run from row 0
            end
        end
    end

    assign wr_done = omem_wr_en && last_q;

endmodule

// File: row_mem.sv
// row-wide single-clock memory with one write port and a registered read, payload set by type
`timescale 1ns/1ps

module row_mem #(
    parameter type payload_t = tpu_bus_pkg::data_row_t  // data rows or result rows
) (
    input  logic                            clk,
    input  logic                            wr_en,
    input  logic [tpu_cfg_pkg::ADDR_W-1:0] wr_addr,
    input  payload_t                        wr_data,
    input  logic                            rd_en,
    input  logic [tpu_cfg_pkg::ADDR_W-1:0] rd_addr,
    output payload_t                        rd_data
);

    payload_t mem_q [tpu_cfg_pkg::MEM_DEPTH];     // one payload per row

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[wr_addr] <= wr_data;            // whole row at once
        end
        if (rd_en) begin
            rd_data <= mem_q[rd_addr];            // data one cycle after rd_en
        end
    end

endmodule

// File: seq_control.sv
// run sequencer: weight read, weight shift, input streaming, then wait for the last write
`timescale 1ns/1ps

module seq_control (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            start,         // one-cycle run request
    input  logic [tpu_cfg_pkg::CNT_W-1:0]  num_rows,      // sampled with start
    input  logic                            wr_done,       // last result row written
    output logic                            busy,
    output logic                            done,
    output logic                            wmem_rd_en,
    output logic [tpu_cfg_pkg::ADDR_W-1:0] wmem_rd_addr,
    output logic                            fifo_push,
    output logic                            w_shift,
    output logic                            imem_rd_en,
    output logic [tpu_cfg_pkg::ADDR_W-1:0] imem_rd_addr,
    output logic                            arr_row_valid,
    output logic                            arr_row_last
);

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_WREAD,                                 // N weight rows, descending address
        PH_WSHIFT,                                // N shifts into the array
        PH_STREAM,                                // one input row per cycle
        PH_WAIT                                   // rows still in the pipeline
    } phase_t;

    phase_t                           phase_q;
    logic [tpu_cfg_pkg::CNT_W-1:0]   cnt_q;       // row or shift count in the phase
    logic [tpu_cfg_pkg::CNT_W-1:0]   rows_q;      // rows in this run
    logic                             ph_end;     // final cycle of a counted phase

    // ====================
    // phase decode
    // ====================
    always_comb begin
        case (phase_q)
            PH_WREAD, PH_WSHIFT: ph_end = (cnt_q == tpu_cfg_pkg::N - 1);
            PH_STREAM:           ph_end = (cnt_q == rows_q - 1'b1);
            default:             ph_end = 1'b0;
        endcase
    end

    assign busy         = (phase_q != PH_IDLE);
    assign wmem_rd_en   = (phase_q == PH_WREAD);
    assign wmem_rd_addr = tpu_cfg_pkg::ADDR_W'(tpu_cfg_pkg::N - 1) - cnt_q[tpu_cfg_pkg::ADDR_W-1:0];
    assign imem_rd_en   = (phase_q == PH_STREAM);
    assign imem_rd_addr = cnt_q[tpu_cfg_pkg::ADDR_W-1:0];

    // ====================
    // sequencing
    // ====================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase_q       <= PH_IDLE;
            cnt_q         <= '0;
            rows_q        <= '0;
            done          <= 1'b0;
            fifo_push     <= 1'b0;
            w_shift       <= 1'b0;
            arr_row_valid <= 1'b0;
            arr_row_last  <= 1'b0;
        end else begin
            fifo_push     <= wmem_rd_en;              // read data lands a cycle later
            w_shift       <= (phase_q == PH_WSHIFT);  // starts after the last push
            arr_row_valid <= imem_rd_en;              // lines up with input mem data
            arr_row_last  <= imem_rd_en && ph_end;
            done          <= (phase_q == PH_WAIT) && wr_done;

            if (phase_q inside {PH_WREAD, PH_WSHIFT, PH_STREAM}) begin
                cnt_q <= ph_end ? '0 : cnt_q + 1'b1;
            end

            case (phase_q)
                PH_IDLE: begin
                    if (start && num_rows != '0) begin  // zero-row start dropped
                        rows_q  <= num_rows;
                        cnt_q   <= '0;
                        phase_q <= PH_WREAD;
                    end
                end
                PH_WREAD:  if (ph_end) phase_q <= PH_WSHIFT;
                PH_WSHIFT: if (ph_end) phase_q <= PH_STREAM;
                PH_STREAM: if (ph_end) phase_q <= PH_WAIT;
                PH_WAIT:   if (wr_done) phase_q <= PH_IDLE;  // busy drops with done
                default:   phase_q <= PH_IDLE;
            endcase
        end
    end

endmodule

// File: sim.f
tpu_cfg_pkg.sv
tpu_bus_pkg.sv
row_mem.sv
weight_fifo.sv
sys_arr.sv
seq_control.sv
out_writer.sv
mmu_top.sv
mmu_checker.sv
mmu_tb.sv

// File: sys_arr.sv
// weight-stationary N by N MAC array, inputs skewed by row, sums flowing down each column
`timescale 1ns/1ps

module sys_arr (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   w_shift,       // weights move one cell down
    input  tpu_bus_pkg::data_row_t w_in,          // enters cell row 0
    input  tpu_bus_pkg::arr_in_t   row_in,
    output tpu_bus_pkg::arr_out_t  row_out
);

    // boundary-extended meshes, cell (k,c) reads [k][c] and drives the next index
    tpu_bus_pkg::data_elem_t wgt  [tpu_cfg_pkg::N+1][tpu_cfg_pkg::N];  // weight, downwards
    tpu_bus_pkg::data_elem_t act  [tpu_cfg_pkg::N][tpu_cfg_pkg::N+1];  // activation, rightwards
    tpu_bus_pkg::acc_elem_t  psum [tpu_cfg_pkg::N+1][tpu_cfg_pkg::N];  // partial sum, downwards

    tpu_bus_pkg::data_row_t  skew_q [tpu_cfg_pkg::N-1];  // stage j delays by j+1
    logic [tpu_cfg_pkg::N-1:0] vld_q;             // valid tag delay line
    logic [tpu_cfg_pkg::N-1:0] lst_q;             // last tag delay line

    // ====================
    // input skew
    // ====================
    always_ff @(posedge clk) begin
        skew_q[0] <= row_in.data;
        for (int j = 1; j < tpu_cfg_pkg::N-1; j++) begin
            skew_q[j] <= skew_q[j-1];
        end
    end

    // tags reach the bottom together with column 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= '0;
            lst_q <= '0;
        end else begin
            vld_q <= {vld_q[tpu_cfg_pkg::N-2:0], row_in.valid};
            lst_q <= {lst_q[tpu_cfg_pkg::N-2:0], row_in.valid && row_in.last};
        end
    end

    // ====================
    // cell mesh
    // ====================
    for (genvar c = 0; c < tpu_cfg_pkg::N; c++) begin : g_top
        assign wgt[0][c]  = w_in[c];              // weight feed from the FIFO
        assign psum[0][c] = '0;                   // no bias, sums start at zero
    end

    for (genvar k = 0; k < tpu_cfg_pkg::N; k++) begin : g_row
        if (k == 0) begin : g_head
            assign act[k][0] = row_in.data[0];    // row 0 needs no delay
        end else begin : g_dly
            assign act[k][0] = skew_q[k-1][k];    // element k delayed k cycles
        end

        for (genvar c = 0; c < tpu_cfg_pkg::N; c++) begin : g_col
            tpu_bus_pkg::data_elem_t wgt_q;       // stationary weight
            tpu_bus_pkg::data_elem_t act_q;
            tpu_bus_pkg::acc_elem_t  psum_q;

            always_ff @(posedge clk) begin
                if (w_shift) begin
                    wgt_q <= wgt[k][c];           // take the weight from above
                end
                act_q  <= act[k][c];
                psum_q <= psum[k][c] + act[k][c] * wgt_q;  // signed MAC
            end

            assign wgt[k+1][c]  = wgt_q;
            assign act[k][c+1]  = act_q;
            assign psum[k+1][c] = psum_q;
        end
    end

    // bottom sums, column c one cycle behind column c-1
    always_comb begin
        row_out.valid = vld_q[tpu_cfg_pkg::N-1];
        row_out.last  = lst_q[tpu_cfg_pkg::N-1];
        for (int c = 0; c < tpu_cfg_pkg::N; c++) begin
            row_out.data[c] = psum[tpu_cfg_pkg::N][c];
        end
    end

endmodule

// File: tpu_bus_pkg.sv
// row and bus types passed between the matrix-multiply blocks and the host
package tpu_bus_pkg;

    // single elements, signed so that element selects stay signed
    typedef logic signed [tpu_cfg_pkg::DATA_W-1:0] data_elem_t;
    typedef logic signed [tpu_cfg_pkg::ACC_W-1:0]  acc_elem_t;

    // whole rows, element 0 in the low bits
    typedef data_elem_t [tpu_cfg_pkg::N-1:0] data_row_t;  // 32 bits
    typedef acc_elem_t  [tpu_cfg_pkg::N-1:0] acc_row_t;   // 72 bits

    // host write strobe into input or weight memory
    typedef struct packed {
        logic                            valid;  // write this cycle
        logic                            sel;    // 0 input mem, 1 weight mem
        logic [tpu_cfg_pkg::ADDR_W-1:0] addr;
        data_row_t                       data;
    } host_wr_t;

    // input row into the array
    typedef struct packed {
        logic      valid;
        logic      last;                         // final row of the run
        data_row_t data;
    } arr_in_t;

    // column-skewed result row out of the array
    typedef struct packed {
        logic     valid;                         // aligned with column 0
        logic     last;
        acc_row_t data;
    } arr_out_t;

endpackage

// File: tpu_cfg_pkg.sv
// array geometry, element widths and memory depth, read by scoped name from every RTL block
package tpu_cfg_pkg;

    // ====================
    // array geometry
    // ====================
    localparam int N = 4;                         // array width and height

    // ====================
    // word widths
    // ====================
    localparam int DATA_W = 8;                    // signed input and weight elements
    localparam int ACC_W  = 18;                   // signed partial sums and results

    // ====================
    // memories and counters
    // ====================
    localparam int MEM_DEPTH = 16;                // rows per memory
    localparam int ADDR_W    = $clog2(MEM_DEPTH); // row address
    localparam int CNT_W     = ADDR_W + 1;        // holds a full count of MEM_DEPTH
    localparam int ARRAY_LAT = 2 * N;             // row in to result write, in cycles

endpackage

// File: weight_fifo.sv
// weight staging between weight memory and the array, filled by push and drained by shift
`timescale 1ns/1ps

module weight_fifo (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   push,          // row_in valid this cycle
    input  logic                   shift,         // array takes col_out this cycle
    input  tpu_bus_pkg::data_row_t row_in,
    output tpu_bus_pkg::data_row_t col_out
);

    // stage 0 is the newest row, stage N-1 the oldest
    tpu_bus_pkg::data_row_t stage_q [tpu_cfg_pkg::N];

    // ====================
    // staging shift
    // ====================
    // push and shift move the same way, only the entry into stage 0 differs
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < tpu_cfg_pkg::N; i++) begin
                stage_q[i] <= '0;                 // empty staging
            end
        end else if (push || shift) begin
            stage_q[0] <= push ? row_in : '0;     // drain fills with zero rows
            for (int i = 1; i < tpu_cfg_pkg::N; i++) begin
                stage_q[i] <= stage_q[i-1];       // older rows move along
            end
        end
    end

    // oldest row faces the array, first row read is first row shifted
    assign col_out = stage_q[tpu_cfg_pkg::N-1];

endmodule
